//--- source/csr_pkg.sv
// CSR unit widths, address codes and ID values
// Request, stage, FPU flag and response structs
package csr_pkg;

    parameter int DATA_BITS     = 32;
    parameter int CSR_ADDR_BITS = 12;
    parameter int NUM_WARPS     = 4;
    parameter int WID_BITS      = 2;
    parameter int NUM_THREADS   = 4;
    parameter int CTR_BITS      = 64;
    parameter int FFLAGS_BITS   = 5;
    parameter int FRM_BITS      = 3;

    // Floating point
    parameter logic [11:0] CSR_FFLAGS      = 12'h001;
    parameter logic [11:0] CSR_FRM         = 12'h002;
    parameter logic [11:0] CSR_FCSR        = 12'h003;
    // Machine mode
    parameter logic [11:0] CSR_SATP        = 12'h180;
    parameter logic [11:0] CSR_MSTATUS     = 12'h300;
    parameter logic [11:0] CSR_MISA        = 12'h301;
    parameter logic [11:0] CSR_MIE         = 12'h304;
    parameter logic [11:0] CSR_MTVEC       = 12'h305;
    parameter logic [11:0] CSR_MEPC        = 12'h341;
    // Counters
    parameter logic [11:0] CSR_MCYCLE      = 12'hB00;
    parameter logic [11:0] CSR_MINSTRET    = 12'hB02;
    parameter logic [11:0] CSR_MCYCLE_H    = 12'hB80;
    parameter logic [11:0] CSR_MINSTRET_H  = 12'hB82;
    // Identity and per-core info
    parameter logic [11:0] CSR_MVENDORID   = 12'hF11;
    parameter logic [11:0] CSR_MARCHID     = 12'hF12;
    parameter logic [11:0] CSR_MIMPID      = 12'hF13;
    parameter logic [11:0] CSR_WARP_ID     = 12'hCC0;
    parameter logic [11:0] CSR_CORE_ID     = 12'hCC1;
    parameter logic [11:0] CSR_THREAD_MASK = 12'hCC2;
    parameter logic [11:0] CSR_WARP_MASK   = 12'hCC3;
    parameter logic [11:0] CSR_NUM_THREADS = 12'hCC4;
    parameter logic [11:0] CSR_NUM_WARPS   = 12'hCC5;

    parameter logic [31:0] VENDOR_ID  = 32'h0000_0a5c;
    parameter logic [31:0] ARCH_ID    = 32'h0000_0002;
    parameter logic [31:0] IMPL_ID    = 32'h0000_0101;
    // MXL=1 (RV32), extensions I, M and F
    parameter logic [31:0] MISA_VALUE = 32'h4000_1120;

    typedef logic [DATA_BITS-1:0] data_t;

    typedef struct packed {
        logic                     write;
        logic [WID_BITS-1:0]      wid;
        logic [CSR_ADDR_BITS-1:0] addr;
        data_t                    data;
    } csr_req_t;

    typedef enum logic [1:0] {
        CLASS_FP, CLASS_INFO, CLASS_ZERO, CLASS_INVALID
    } csr_class_t;

    typedef enum logic [1:0] {
        FIELD_FLAGS, FIELD_FRM, FIELD_FULL
    } fp_field_t;

    typedef struct packed {
        csr_req_t   req;
        csr_class_t cls;
        fp_field_t  field;
    } csr_stage_t;

    typedef struct packed {
        logic                   valid;
        logic [WID_BITS-1:0]    wid;
        logic [FFLAGS_BITS-1:0] flags;
    } fpu_flags_t;

    typedef struct packed {
        data_t data;
        logic  error;
    } csr_rsp_t;

endpackage

//--- source/csr_request_decode.sv
// Request input stage with address classification
`timescale 1ns/10ps

module csr_request_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  csr_pkg::csr_req_t   req,
    output logic                req_ready,
    output logic                stage_valid,
    output csr_pkg::csr_stage_t stage,
    input  logic                stage_ready
);

    logic                full;
    csr_pkg::csr_stage_t stage_r;
    csr_pkg::csr_class_t cls;
    csr_pkg::fp_field_t  field;

    // Register takes a new request when empty or draining this cycle
    assign req_ready = ~full | stage_ready;

    always_comb begin
        cls   = csr_pkg::CLASS_INVALID;
        field = csr_pkg::FIELD_FULL;
        case (req.addr)
            csr_pkg::CSR_FFLAGS: begin
                cls   = csr_pkg::CLASS_FP;
                field = csr_pkg::FIELD_FLAGS;
            end
            csr_pkg::CSR_FRM: begin
                cls   = csr_pkg::CLASS_FP;
                field = csr_pkg::FIELD_FRM;
            end
            csr_pkg::CSR_FCSR: cls = csr_pkg::CLASS_FP;
            csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID,
            csr_pkg::CSR_MISA, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MCYCLE_H,
            csr_pkg::CSR_MINSTRET, csr_pkg::CSR_MINSTRET_H,
            csr_pkg::CSR_WARP_ID, csr_pkg::CSR_CORE_ID, csr_pkg::CSR_THREAD_MASK,
            csr_pkg::CSR_WARP_MASK, csr_pkg::CSR_NUM_THREADS,
            csr_pkg::CSR_NUM_WARPS: cls = csr_pkg::CLASS_INFO;
            csr_pkg::CSR_SATP, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC: cls = csr_pkg::CLASS_ZERO;
            default: ;
        endcase
        // Info space is read-only
        if (req.write && cls == csr_pkg::CLASS_INFO) begin
            cls = csr_pkg::CLASS_INVALID;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (req_ready) begin
            full <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            stage_r.req   <= req;
            stage_r.cls   <= cls;
            stage_r.field <= field;
        end
    end

    assign stage_valid = full;
    assign stage       = stage_r;

endmodule

//--- source/fcsr_file.sv
// Per-warp rounding mode and sticky FP exception flags
`timescale 1ns/10ps

module fcsr_file #(
    parameter int NUM_FPU_PORTS = 1
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               stage_valid,
    input  logic                                               stage_ready,
    input  csr_pkg::csr_stage_t                                stage,
    input  csr_pkg::fpu_flags_t [NUM_FPU_PORTS-1:0]            fpu_flags,
    input  logic [NUM_FPU_PORTS-1:0][csr_pkg::WID_BITS-1:0]    frm_wid,
    output logic [NUM_FPU_PORTS-1:0][csr_pkg::FRM_BITS-1:0]    frm,
    output csr_pkg::data_t                                     fp_rdata
);

    logic [csr_pkg::NUM_WARPS-1:0][csr_pkg::FRM_BITS-1:0]    frm_r, frm_n;
    logic [csr_pkg::NUM_WARPS-1:0][csr_pkg::FFLAGS_BITS-1:0] flags_r, flags_n;
    logic                                                    csr_write;
    logic [csr_pkg::WID_BITS-1:0]                            wwid;

    assign csr_write = stage_valid && stage_ready && stage.req.write
                    && stage.cls == csr_pkg::CLASS_FP;
    assign wwid = stage.req.wid;

    always_comb begin
        frm_n   = frm_r;
        flags_n = flags_r;
        for (int i = 0; i < NUM_FPU_PORTS; i++) begin
            if (fpu_flags[i].valid) begin
                flags_n[fpu_flags[i].wid] = flags_n[fpu_flags[i].wid] | fpu_flags[i].flags;
            end
        end
        // CSR write overrides any FPU update to the same warp
        if (csr_write) begin
            case (stage.field)
                csr_pkg::FIELD_FLAGS: flags_n[wwid] = stage.req.data[csr_pkg::FFLAGS_BITS-1:0];
                csr_pkg::FIELD_FRM:   frm_n[wwid]   = stage.req.data[csr_pkg::FRM_BITS-1:0];
                csr_pkg::FIELD_FULL: begin
                    flags_n[wwid] = stage.req.data[csr_pkg::FFLAGS_BITS-1:0];
                    frm_n[wwid]   = stage.req.data[csr_pkg::FFLAGS_BITS +: csr_pkg::FRM_BITS];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frm_r   <= '0;
            flags_r <= '0;
        end else begin
            frm_r   <= frm_n;
            flags_r <= flags_n;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FPU_PORTS; i++) begin
            frm[i] = frm_r[frm_wid[i]];
        end
    end

    // fcsr layout is {frm, fflags}
    always_comb begin
        case (stage.field)
            csr_pkg::FIELD_FLAGS: fp_rdata = csr_pkg::data_t'(flags_r[stage.req.wid]);
            csr_pkg::FIELD_FRM:   fp_rdata = csr_pkg::data_t'(frm_r[stage.req.wid]);
            csr_pkg::FIELD_FULL:
                fp_rdata = csr_pkg::data_t'({frm_r[stage.req.wid], flags_r[stage.req.wid]});
            default:              fp_rdata = '0;
        endcase
    end

endmodule

//--- source/csr_read_mux.sv
// Read value select and response register
`timescale 1ns/10ps

module csr_read_mux #(
    parameter int CORE_ID = 0
) (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic                                                      stage_valid,
    input  csr_pkg::csr_stage_t                                       stage,
    output logic                                                      stage_ready,
    input  csr_pkg::data_t                                            fp_rdata,
    input  logic [csr_pkg::CTR_BITS-1:0]                              cycles,
    input  logic [csr_pkg::CTR_BITS-1:0]                              instret,
    input  logic [csr_pkg::NUM_WARPS-1:0]                             active_warps,
    input  logic [csr_pkg::NUM_WARPS-1:0][csr_pkg::NUM_THREADS-1:0]   thread_masks,
    output logic                                                      rsp_valid,
    output csr_pkg::csr_rsp_t                                         rsp,
    input  logic                                                      rsp_ready
);

    localparam int LO = csr_pkg::DATA_BITS;
    localparam int HI = csr_pkg::CTR_BITS;

    csr_pkg::data_t    info_data;
    csr_pkg::csr_rsp_t rsp_n;
    csr_pkg::csr_rsp_t rsp_r;
    logic              rsp_valid_r;

    // Stage moves on whenever the response slot is free or draining
    assign stage_ready = ~rsp_valid_r | rsp_ready;

    always_comb begin
        case (stage.req.addr)
            csr_pkg::CSR_MVENDORID:   info_data = csr_pkg::VENDOR_ID;
            csr_pkg::CSR_MARCHID:     info_data = csr_pkg::ARCH_ID;
            csr_pkg::CSR_MIMPID:      info_data = csr_pkg::IMPL_ID;
            csr_pkg::CSR_MISA:        info_data = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MCYCLE:      info_data = cycles[LO-1:0];
            csr_pkg::CSR_MCYCLE_H:    info_data = cycles[HI-1:LO];
            csr_pkg::CSR_MINSTRET:    info_data = instret[LO-1:0];
            csr_pkg::CSR_MINSTRET_H:  info_data = instret[HI-1:LO];
            csr_pkg::CSR_WARP_ID:     info_data = csr_pkg::data_t'(stage.req.wid);
            csr_pkg::CSR_CORE_ID:     info_data = csr_pkg::data_t'(CORE_ID);
            csr_pkg::CSR_THREAD_MASK:
                info_data = csr_pkg::data_t'(thread_masks[stage.req.wid]);
            csr_pkg::CSR_WARP_MASK:   info_data = csr_pkg::data_t'(active_warps);
            csr_pkg::CSR_NUM_THREADS: info_data = csr_pkg::data_t'(csr_pkg::NUM_THREADS);
            csr_pkg::CSR_NUM_WARPS:   info_data = csr_pkg::data_t'(csr_pkg::NUM_WARPS);
            default:                  info_data = '0;
        endcase
    end

    always_comb begin
        rsp_n.data  = '0;
        rsp_n.error = (stage.cls == csr_pkg::CLASS_INVALID);
        // Writes always answer with zero data
        if (!stage.req.write) begin
            case (stage.cls)
                csr_pkg::CLASS_FP:   rsp_n.data = fp_rdata;
                csr_pkg::CLASS_INFO: rsp_n.data = info_data;
                default:             rsp_n.data = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_r <= 1'b0;
        end else if (stage_ready) begin
            rsp_valid_r <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_valid && stage_ready) begin
            rsp_r <= rsp_n;
        end
    end

    assign rsp_valid = rsp_valid_r;
    assign rsp       = rsp_r;

endmodule

//--- source/csr_unit.sv
// CSR unit top: decode, FP register file and read/response stage
`timescale 1ns/10ps

module csr_unit #(
    parameter int CORE_ID       = 0,
    parameter int NUM_FPU_PORTS = 1
) (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic                                                      req_valid,
    input  csr_pkg::csr_req_t                                         req,
    output logic                                                      req_ready,
    output logic                                                      rsp_valid,
    output csr_pkg::csr_rsp_t                                         rsp,
    input  logic                                                      rsp_ready,
    input  csr_pkg::fpu_flags_t [NUM_FPU_PORTS-1:0]                   fpu_flags,
    input  logic [NUM_FPU_PORTS-1:0][csr_pkg::WID_BITS-1:0]           frm_wid,
    output logic [NUM_FPU_PORTS-1:0][csr_pkg::FRM_BITS-1:0]           frm,
    input  logic [csr_pkg::CTR_BITS-1:0]                              cycles,
    input  logic [csr_pkg::CTR_BITS-1:0]                              instret,
    input  logic [csr_pkg::NUM_WARPS-1:0]                             active_warps,
    input  logic [csr_pkg::NUM_WARPS-1:0][csr_pkg::NUM_THREADS-1:0]   thread_masks
);

    logic                stage_valid;
    logic                stage_ready;
    csr_pkg::csr_stage_t stage;
    csr_pkg::data_t      fp_rdata;

    csr_request_decode decode_inst (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .stage_valid (stage_valid),
        .stage       (stage),
        .stage_ready (stage_ready)
    );

    fcsr_file #(
        .NUM_FPU_PORTS (NUM_FPU_PORTS)
    ) fcsr_inst (
        .clk         (clk),
        .reset       (reset),
        .stage_valid (stage_valid),
        .stage_ready (stage_ready),
        .stage       (stage),
        .fpu_flags   (fpu_flags),
        .frm_wid     (frm_wid),
        .frm         (frm),
        .fp_rdata    (fp_rdata)
    );

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) read_inst (
        .clk          (clk),
        .reset        (reset),
        .stage_valid  (stage_valid),
        .stage        (stage),
        .stage_ready  (stage_ready),
        .fp_rdata     (fp_rdata),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready)
    );

endmodule

//--- bench/clock_gen.sv
// Testbench clock and power-on reset
`timescale 1ns/10ps

module clock_gen #(
    parameter real PERIOD       = 40.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- bench/csr_unit_tb.sv
// CSR unit testbench with reference model and response scoreboard
`timescale 1ns/10ps

module csr_unit_tb;

    localparam int CORE_ID = 5;

    logic clk, reset, req_valid, req_ready, rsp_valid, rsp_ready;
    csr_pkg::csr_req_t   req;
    csr_pkg::csr_rsp_t   rsp;
    csr_pkg::fpu_flags_t [1:0] fpu_flags;
    logic [1:0][1:0]     frm_wid;
    logic [1:0][2:0]     frm;
    logic [63:0]         cycles, instret;
    logic [3:0]          active_warps;
    logic [3:0][3:0]     thread_masks;

    // Reference FP state per warp
    logic [4:0]  m_flags [4];
    logic [2:0]  m_frm [4];
    csr_pkg::csr_rsp_t exp_q [$];
    string       name_q [$];
    string       test_name;
    logic [11:0] info_addrs [10];
    logic [11:0] rnd_addrs [6];
    logic [31:0] op;
    integer      seed = 32'hda32276f;
    int          value_errors = 0;
    int          other_errors = 0;
    int          issued = 0;
    int          cycle_count = 0;
    logic        sent_any = 1'b0;
    logic        backpressure = 1'b0;

    clock_gen #(.PERIOD(40.0), .RESET_CYCLES(3)) clock_inst (.clk(clk), .reset(reset));

    csr_unit #(.CORE_ID(CORE_ID), .NUM_FPU_PORTS(2)) csr_unit_inst (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready), .fpu_flags(fpu_flags),
        .frm_wid(frm_wid), .frm(frm), .cycles(cycles), .instret(instret),
        .active_warps(active_warps), .thread_masks(thread_masks)
    );

    // Expected response from the CSR map, updating the model on FP writes
    task automatic predict(input csr_pkg::csr_req_t q, output csr_pkg::csr_rsp_t r);
        logic [31:0] v;
        logic        info;
        logic        known;
        v = '0;
        info = 1'b1;
        known = 1'b1;
        case (q.addr)
            csr_pkg::CSR_FFLAGS: begin
                info = 1'b0;
                v = 32'(m_flags[q.wid]);
                if (q.write) m_flags[q.wid] = q.data[4:0];
            end
            csr_pkg::CSR_FRM: begin
                info = 1'b0;
                v = 32'(m_frm[q.wid]);
                if (q.write) m_frm[q.wid] = q.data[2:0];
            end
            csr_pkg::CSR_FCSR: begin
                info = 1'b0;
                v = 32'({m_frm[q.wid], m_flags[q.wid]});
                if (q.write) begin
                    m_flags[q.wid] = q.data[4:0];
                    m_frm[q.wid] = q.data[7:5];
                end
            end
            csr_pkg::CSR_SATP, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC: info = 1'b0;
            csr_pkg::CSR_MVENDORID:   v = csr_pkg::VENDOR_ID;
            csr_pkg::CSR_MARCHID:     v = csr_pkg::ARCH_ID;
            csr_pkg::CSR_MIMPID:      v = csr_pkg::IMPL_ID;
            // MXL of 1 plus extension bits I, M and F
            csr_pkg::CSR_MISA:        v = 32'h4000_0000 | (32'd1 << 8) | (32'd1 << 12)
                                          | (32'd1 << 5);
            csr_pkg::CSR_MCYCLE:      v = cycles[31:0];
            csr_pkg::CSR_MCYCLE_H:    v = cycles[63:32];
            csr_pkg::CSR_MINSTRET:    v = instret[31:0];
            csr_pkg::CSR_MINSTRET_H:  v = instret[63:32];
            csr_pkg::CSR_WARP_ID:     v = 32'(q.wid);
            csr_pkg::CSR_CORE_ID:     v = CORE_ID;
            csr_pkg::CSR_THREAD_MASK: v = 32'(thread_masks[q.wid]);
            csr_pkg::CSR_WARP_MASK:   v = 32'(active_warps);
            csr_pkg::CSR_NUM_THREADS: v = 4;
            csr_pkg::CSR_NUM_WARPS:   v = 4;
            default:                  known = 1'b0;
        endcase
        r.error = !known || (q.write && info);
        r.data = (q.write || r.error) ? '0 : v;
    endtask

    // Holds valid until the request is taken; valid stays high for back-to-back use
    task automatic issue(input logic wr, input logic [1:0] wid, input logic [11:0] addr,
                         input logic [31:0] data);
        csr_pkg::csr_req_t q;
        csr_pkg::csr_rsp_t r;
        q.write = wr;
        q.wid = wid;
        q.addr = addr;
        q.data = data;
        issued++;
        sent_any = 1'b1;
        req_valid <= 1'b1;
        req <= q;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        predict(q, r);
        exp_q.push_back(r);
        name_q.push_back(test_name);
    endtask

    task automatic drain();
        req_valid <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic fpu_update(input logic [1:0] w0, input logic [4:0] f0,
                              input logic [1:0] w1, input logic [4:0] f1);
        fpu_flags[0] <= '{valid: 1'b1, wid: w0, flags: f0};
        fpu_flags[1] <= '{valid: 1'b1, wid: w1, flags: f1};
        @(posedge clk);
        fpu_flags <= '0;
        m_flags[w0] = m_flags[w0] | f0;
        m_flags[w1] = m_flags[w1] | f1;
    endtask

    task automatic check_frm();
        for (int w = 0; w < 4; w++) begin
            frm_wid[0] <= 2'(w);
            frm_wid[1] <= 2'(3 - w);
            @(negedge clk);
            assert (frm[0] == m_frm[w]) else begin
                value_errors++;
                $display("error %s frm port 0 warp %0d: expected %h actual %h",
                         test_name, w, m_frm[w], frm[0]);
            end
            assert (frm[1] == m_frm[3 - w]) else begin
                value_errors++;
                $display("error %s frm port 1 warp %0d: expected %h actual %h",
                         test_name, 3 - w, m_frm[3 - w], frm[1]);
            end
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        rsp_ready <= backpressure ? 1'($random(seed)) : 1'b1;
    end

    // Scoreboard
    always @(posedge clk) begin : monitor
        csr_pkg::csr_rsp_t exp;
        string             name;
        if (!reset) begin
            if (!sent_any) begin
                assert (!rsp_valid) else begin
                    other_errors++;
                    $display("rsp_valid went high before any request was sent");
                end
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("a response arrived with no request outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    name = name_q.pop_front();
                    assert (rsp == exp) else begin
                        value_errors++;
                        $display("error %s: expected %h/%b actual %h/%b",
                                 name, exp.data, exp.error, rsp.data, rsp.error);
                    end
                end
            end
        end
    end

    // Limit grows with the number of requests issued
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 40 * issued + 100) begin
            $display("Timeout: the run stopped making progress after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        fpu_flags = '0;
        frm_wid = '0;
        cycles = 64'h1234_5678_9abc_def0;
        instret = 64'h0fed_cba9_8765_4321;
        active_warps = 4'b1011;
        thread_masks = {4'h9, 4'h6, 4'hc, 4'h3};
        for (int w = 0; w < 4; w++) begin
            m_flags[w] = '0;
            m_frm[w] = '0;
        end
        info_addrs = '{csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID,
                       csr_pkg::CSR_MISA, csr_pkg::CSR_CORE_ID, csr_pkg::CSR_WARP_ID,
                       csr_pkg::CSR_THREAD_MASK, csr_pkg::CSR_WARP_MASK,
                       csr_pkg::CSR_NUM_THREADS, csr_pkg::CSR_NUM_WARPS};
        rnd_addrs = '{csr_pkg::CSR_FFLAGS, csr_pkg::CSR_FRM, csr_pkg::CSR_FCSR,
                      csr_pkg::CSR_WARP_ID, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MSTATUS};
        wait (!reset);
        repeat (3) @(posedge clk);

        test_name = "info_reads";
        for (int w = 0; w < 4; w++) begin
            for (int i = 0; i < 10; i++) issue(1'b0, 2'(w), info_addrs[i], '0);
        end
        test_name = "counter_reads";
        issue(1'b0, 2'd0, csr_pkg::CSR_MCYCLE, '0);
        issue(1'b0, 2'd1, csr_pkg::CSR_MCYCLE_H, '0);
        issue(1'b0, 2'd2, csr_pkg::CSR_MINSTRET, '0);
        issue(1'b0, 2'd3, csr_pkg::CSR_MINSTRET_H, '0);
        drain();

        test_name = "fp_write_read";
        issue(1'b1, 2'd0, csr_pkg::CSR_FFLAGS, 32'h0000_0015);
        issue(1'b1, 2'd1, csr_pkg::CSR_FRM, 32'hffff_fffb);
        issue(1'b1, 2'd2, csr_pkg::CSR_FCSR, 32'h0000_01a7);
        for (int w = 0; w < 4; w++) begin
            issue(1'b0, 2'(w), csr_pkg::CSR_FFLAGS, '0);
            issue(1'b0, 2'(w), csr_pkg::CSR_FRM, '0);
            issue(1'b0, 2'(w), csr_pkg::CSR_FCSR, '0);
        end
        drain();

        test_name = "fpu_sticky";
        fpu_update(2'd3, 5'h01, 2'd3, 5'h08);
        fpu_update(2'd3, 5'h04, 2'd0, 5'h02);
        issue(1'b1, 2'd1, csr_pkg::CSR_FFLAGS, 32'h0000_0002);
        // FPU port 0 hits the warp being written, port 1 another warp
        req_valid <= 1'b0;
        fpu_flags[0] <= '{valid: 1'b1, wid: 2'd1, flags: 5'h19};
        fpu_flags[1] <= '{valid: 1'b1, wid: 2'd2, flags: 5'h10};
        @(posedge clk);
        fpu_flags <= '0;
        m_flags[2] = m_flags[2] | 5'h10;
        for (int w = 0; w < 4; w++) issue(1'b0, 2'(w), csr_pkg::CSR_FCSR, '0);
        drain();
        check_frm();

        test_name = "zero_and_invalid";
        issue(1'b0, 2'd2, csr_pkg::CSR_SATP, '0);
        issue(1'b1, 2'd2, csr_pkg::CSR_SATP, 32'hdead_beef);
        issue(1'b1, 2'd0, csr_pkg::CSR_MSTATUS, 32'h0000_1888);
        issue(1'b1, 2'd0, csr_pkg::CSR_MIE, 32'hffff_ffff);
        issue(1'b1, 2'd1, csr_pkg::CSR_MTVEC, 32'h8000_0000);
        issue(1'b1, 2'd3, csr_pkg::CSR_MEPC, 32'h0000_1234);
        issue(1'b0, 2'd2, csr_pkg::CSR_SATP, '0);
        issue(1'b0, 2'd0, csr_pkg::CSR_MSTATUS, '0);
        issue(1'b0, 2'd0, csr_pkg::CSR_MIE, '0);
        issue(1'b0, 2'd1, csr_pkg::CSR_MTVEC, '0);
        issue(1'b0, 2'd3, csr_pkg::CSR_MEPC, '0);
        issue(1'b0, 2'd0, 12'h7ff, '0);
        issue(1'b1, 2'd1, 12'hcc6, 32'h0000_00ff);
        issue(1'b1, 2'd2, 12'h004, 32'h0000_00ff);
        for (int i = 0; i < 10; i++) issue(1'b1, 2'(i % 4), info_addrs[i], 32'h0000_00ff);
        for (int w = 0; w < 4; w++) issue(1'b0, 2'(w), csr_pkg::CSR_FCSR, '0);
        drain();

        test_name = "backpressure";
        backpressure = 1'b1;
        for (int n = 0; n < 40; n++) begin
            op = $random(seed);
            issue(op[0], op[2:1], rnd_addrs[op[6:3] % 6], $random(seed));
        end
        drain();
        backpressure = 1'b0;
        check_frm();
        repeat (4) @(posedge clk);

        $display("Closing report: %0d value errors, %0d protocol errors, %0d requests",
                 value_errors, other_errors, issued);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/csr_pkg.sv
source/csr_request_decode.sv
source/fcsr_file.sv
source/csr_read_mux.sv
source/csr_unit.sv
bench/clock_gen.sv
bench/csr_unit_tb.sv
